//--- ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// operand and result width
`define EX_WORD_W 32

// full product, or {remainder, quotient}
`define EX_DWORD_W 64

// byte lanes in one word
`define EX_LANES 4

// one quotient bit per step
`define EX_DIV_STEPS 32

`endif

//--- ex_pkg.sv
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_WORD_W-1:0]  word_t;
    typedef logic [`EX_DWORD_W-1:0] dword_t;
    typedef logic [`EX_LANES-1:0]   lane_mask_t;

    // one-hot, bit k rotates right by k bytes
    typedef logic [`EX_LANES-1:0]   lane_sel_t;

    // one-hot op codes, bit 0 first in the lists below
    // beq bne bgez bgtz blez bltz
    typedef logic [5:0] br_op_t;
    // lwr lwl lhu lh lbu lb lw
    typedef logic [6:0] ld_op_t;
    // swr swl sh sb sw
    typedef logic [4:0] st_op_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX,
        DIV_DONE
    } div_state_t;

    typedef logic [$clog2(`EX_DIV_STEPS):0] step_cnt_t;

    // byte rotator shared by the load and store paths
    function automatic word_t rot_right_lanes(word_t data, lane_sel_t sel);
        return {`EX_WORD_W{sel[0]}} & data
             | {`EX_WORD_W{sel[1]}} & {data[7:0],  data[31:8]}
             | {`EX_WORD_W{sel[2]}} & {data[15:0], data[31:16]}
             | {`EX_WORD_W{sel[3]}} & {data[23:0], data[31:24]};
    endfunction

endpackage

//--- ex_ctrl.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic div_start,
    input  logic div_ack,
    output logic div_busy,
    output logic div_done,
    output logic div_load,
    output logic div_step,
    output logic div_fix,
    output logic div_commit
);
    import ex_pkg::*;

    div_state_t state;
    step_cnt_t  step_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    // starts seen while busy or done are simply dropped
                    if (div_start) begin
                        state    <= DIV_RUN;
                        step_cnt <= '0;
                    end
                end
                DIV_RUN: begin
                    step_cnt <= step_cnt + step_cnt_t'(1);
                    if (step_cnt == step_cnt_t'(`EX_DIV_STEPS - 1)) begin
                        state <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state <= DIV_DONE;
                end
                DIV_DONE: begin
                    if (div_commit) begin
                        state <= DIV_IDLE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // done rises one cycle after entering DIV_DONE, held until acked
    always_ff @(posedge clk) begin
        if (rst) begin
            div_done <= 1'b0;
        end else if (div_commit) begin
            div_done <= 1'b0;
        end else if (state == DIV_DONE) begin
            div_done <= 1'b1;
        end
    end

    assign div_load   = (state == DIV_IDLE) && div_start;
    assign div_step   = (state == DIV_RUN);
    assign div_fix    = (state == DIV_FIX);
    assign div_busy   = (state != DIV_IDLE);
    assign div_commit = div_done && div_ack;

endmodule

//--- div_iter.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module div_iter (
    input  logic          clk,
    input  logic          div_signed,
    input  ex_pkg::word_t dividend,
    input  ex_pkg::word_t divisor,
    input  logic          div_load,
    input  logic          div_step,
    input  logic          div_fix,
    output ex_pkg::word_t quotient,
    output ex_pkg::word_t remainder
);
    import ex_pkg::*;

    word_t rem_q;
    word_t quo_q;
    word_t dvsr_q;
    logic  dvd_neg;
    logic  dvsr_neg;

    logic  dvd_sign;
    logic  dvsr_sign;
    word_t dvd_abs;
    word_t dvsr_abs;

    // partial remainder needs one extra bit before the compare
    logic [`EX_WORD_W:0] shifted;
    logic [`EX_WORD_W:0] diff;

    assign dvd_sign  = div_signed && dividend[`EX_WORD_W-1];
    assign dvsr_sign = div_signed && divisor[`EX_WORD_W-1];
    assign dvd_abs   = dvd_sign  ? -dividend : dividend;
    assign dvsr_abs  = dvsr_sign ? -divisor  : divisor;

    assign shifted = {rem_q, quo_q[`EX_WORD_W-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (div_load) begin
            rem_q    <= '0;
            quo_q    <= dvd_abs;
            dvsr_q   <= dvsr_abs;
            dvd_neg  <= dvd_sign;
            dvsr_neg <= dvsr_sign;
        end else if (div_step) begin
            // dividend bits shift out the top while quotient bits enter below
            if (!diff[`EX_WORD_W]) begin
                rem_q <= diff[`EX_WORD_W-1:0];
                quo_q <= {quo_q[`EX_WORD_W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`EX_WORD_W-1:0];
                quo_q <= {quo_q[`EX_WORD_W-2:0], 1'b0};
            end
        end else if (div_fix) begin
            // truncating division, remainder follows the dividend sign
            if (dvd_neg ^ dvsr_neg) begin
                quo_q <= -quo_q;
            end
            if (dvd_neg) begin
                rem_q <= -rem_q;
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

//--- hilo_unit.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module hilo_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic          mul_en,
    input  logic          mul_signed,
    input  ex_pkg::word_t src1,
    input  ex_pkg::word_t src2,
    input  logic          div_commit,
    input  ex_pkg::word_t quotient,
    input  ex_pkg::word_t remainder,
    output ex_pkg::word_t hi,
    output ex_pkg::word_t lo
);
    import ex_pkg::*;

    dword_t prod_s;
    dword_t prod_u;
    dword_t prod;

    // mul_signed picks the signed or the unsigned product
    assign prod_s = $signed(src1) * $signed(src2);
    assign prod_u = src1 * src2;
    assign prod   = mul_signed ? prod_s : prod_u;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (mul_en) begin
            // multiply takes priority over a divide commit
            hi <= prod[`EX_DWORD_W-1:`EX_WORD_W];
            lo <= prod[`EX_WORD_W-1:0];
        end else if (div_commit) begin
            hi <= remainder;
            lo <= quotient;
        end
    end

endmodule

//--- br_comp.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module br_comp (
    input  ex_pkg::br_op_t br_op,
    input  ex_pkg::word_t  src1,
    input  ex_pkg::word_t  src2,
    output logic           br_taken
);

    logic src_eq;
    logic src1_zero;
    logic src1_neg;

    assign src_eq    = (src1 == src2);
    assign src1_zero = (src1 == '0);
    assign src1_neg  = src1[`EX_WORD_W-1];

    // op bits: beq bne bgez bgtz blez bltz
    assign br_taken = br_op[0] &&  src_eq
                   || br_op[1] && !src_eq
                   || br_op[2] && !src1_neg
                   || br_op[3] && !src1_neg && !src1_zero
                   || br_op[4] && (src1_neg || src1_zero)
                   || br_op[5] &&  src1_neg;

endmodule

//--- ld_align.sv
`timescale 1ns/1ps

module ld_align (
    input  ex_pkg::ld_op_t     ld_op,
    input  logic [1:0]         addr_low,
    input  ex_pkg::word_t      mem_rdata,
    input  logic               gr_we,
    output ex_pkg::word_t      ld_result,
    output ex_pkg::lane_mask_t reg_we_mask
);
    import ex_pkg::*;

    logic       op_lwr, op_lwl, op_lhu, op_lh, op_lbu, op_lb, op_lw;
    logic       op_byte, op_half, op_full, no_load;
    lane_mask_t a;
    lane_sel_t  rot;
    word_t      rotated;

    assign {op_lw, op_lb, op_lbu, op_lh, op_lhu, op_lwl, op_lwr} = ld_op;

    assign op_byte = op_lb || op_lbu;
    assign op_half = op_lh || op_lhu;
    assign op_full = op_lw || op_byte || op_half;
    assign no_load = (ld_op == '0);

    // one-hot byte address
    assign a = lane_mask_t'(1) << addr_low;

    // lwl brings lane a up to lane 3, lwr brings lane a down to lane 0
    assign rot[0] = op_lw || (op_byte || op_half) && a[0] || op_lwl && a[3] || op_lwr && a[0];
    assign rot[1] = op_byte && a[1] || op_lwl && a[0] || op_lwr && a[1];
    assign rot[2] = (op_byte || op_half) && a[2] || op_lwl && a[1] || op_lwr && a[2];
    assign rot[3] = op_byte && a[3] || op_lwl && a[2] || op_lwr && a[3];

    assign rotated = rot_right_lanes(mem_rdata, rot);

    always_comb begin
        if (op_lb) begin
            ld_result = {{24{rotated[7]}}, rotated[7:0]};
        end else if (op_lbu) begin
            ld_result = {24'b0, rotated[7:0]};
        end else if (op_lh) begin
            ld_result = {{16{rotated[15]}}, rotated[15:0]};
        end else if (op_lhu) begin
            ld_result = {16'b0, rotated[15:0]};
        end else begin
            ld_result = rotated;
        end
    end

    // lwl keeps the low register bytes, lwr the high ones
    assign reg_we_mask[0] = op_full || no_load && gr_we || op_lwl && a[3] || op_lwr;
    assign reg_we_mask[1] = op_full || no_load && gr_we
                         || op_lwl && (a[3] || a[2])
                         || op_lwr && (a[0] || a[1] || a[2]);
    assign reg_we_mask[2] = op_full || no_load && gr_we
                         || op_lwl && (a[3] || a[2] || a[1])
                         || op_lwr && (a[0] || a[1]);
    assign reg_we_mask[3] = op_full || no_load && gr_we || op_lwl || op_lwr && a[0];

endmodule

//--- st_align.sv
`timescale 1ns/1ps

module st_align (
    input  ex_pkg::st_op_t     st_op,
    input  logic [1:0]         addr_low,
    input  ex_pkg::word_t      rt_data,
    output ex_pkg::word_t      st_data,
    output ex_pkg::lane_mask_t mem_we
);
    import ex_pkg::*;

    logic       op_swr, op_swl, op_sh, op_sb, op_sw;
    lane_mask_t a;
    lane_sel_t  rot;

    assign {op_sw, op_sb, op_sh, op_swl, op_swr} = st_op;

    assign a = lane_mask_t'(1) << addr_low;

    // sb, sh and swr shift left by a, swl puts byte 3 at lane a
    assign rot[0] = op_sw || op_sb && a[0] || op_sh && a[0] || op_swl && a[3] || op_swr && a[0];
    assign rot[1] = op_sb && a[3] || op_swl && a[2] || op_swr && a[3];
    assign rot[2] = op_sb && a[2] || op_sh && a[2] || op_swl && a[1] || op_swr && a[2];
    assign rot[3] = op_sb && a[1] || op_swl && a[0] || op_swr && a[1];

    assign st_data = rot_right_lanes(rt_data, rot);

    assign mem_we[0] = op_sw || op_sb && a[0] || op_sh && a[0] || op_swl || op_swr && a[0];
    assign mem_we[1] = op_sw || op_sb && a[1] || op_sh && a[0]
                    || op_swl && (a[3] || a[2] || a[1])
                    || op_swr && (a[0] || a[1]);
    assign mem_we[2] = op_sw || op_sb && a[2] || op_sh && a[2]
                    || op_swl && (a[3] || a[2])
                    || op_swr && (a[0] || a[1] || a[2]);
    assign mem_we[3] = op_sw || op_sb && a[3] || op_sh && a[2] || op_swl && a[3] || op_swr;

endmodule

//--- ex_mem_unit.sv
`timescale 1ns/1ps

module ex_mem_unit (
    input  logic               clk,
    input  logic               rst,
    input  ex_pkg::word_t      src1,
    input  ex_pkg::word_t      src2,
    input  logic               div_start,
    input  logic               div_signed,
    input  logic               div_ack,
    output logic               div_busy,
    output logic               div_done,
    input  logic               mul_en,
    input  logic               mul_signed,
    output ex_pkg::word_t      hi,
    output ex_pkg::word_t      lo,
    input  ex_pkg::br_op_t     br_op,
    output logic               br_taken,
    input  logic [1:0]         addr_low,
    input  ex_pkg::ld_op_t     ld_op,
    input  ex_pkg::word_t      mem_rdata,
    input  logic               gr_we,
    output ex_pkg::word_t      ld_result,
    output ex_pkg::lane_mask_t reg_we_mask,
    input  ex_pkg::st_op_t     st_op,
    input  ex_pkg::word_t      rt_data,
    output ex_pkg::word_t      st_data,
    output ex_pkg::lane_mask_t mem_we
);
    import ex_pkg::*;

    logic  div_load;
    logic  div_step;
    logic  div_fix;
    logic  div_commit;
    word_t quotient;
    word_t remainder;

    ex_ctrl u_ex_ctrl (
        .clk        (clk),
        .rst        (rst),
        .div_start  (div_start),
        .div_ack    (div_ack),
        .div_busy   (div_busy),
        .div_done   (div_done),
        .div_load   (div_load),
        .div_step   (div_step),
        .div_fix    (div_fix),
        .div_commit (div_commit)
    );

    div_iter u_div_iter (
        .clk        (clk),
        .div_signed (div_signed),
        .dividend   (src1),
        .divisor    (src2),
        .div_load   (div_load),
        .div_step   (div_step),
        .div_fix    (div_fix),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    hilo_unit u_hilo_unit (
        .clk        (clk),
        .rst        (rst),
        .mul_en     (mul_en),
        .mul_signed (mul_signed),
        .src1       (src1),
        .src2       (src2),
        .div_commit (div_commit),
        .quotient   (quotient),
        .remainder  (remainder),
        .hi         (hi),
        .lo         (lo)
    );

    br_comp u_br_comp (
        .br_op    (br_op),
        .src1     (src1),
        .src2     (src2),
        .br_taken (br_taken)
    );

    ld_align u_ld_align (
        .ld_op       (ld_op),
        .addr_low    (addr_low),
        .mem_rdata   (mem_rdata),
        .gr_we       (gr_we),
        .ld_result   (ld_result),
        .reg_we_mask (reg_we_mask)
    );

    st_align u_st_align (
        .st_op    (st_op),
        .addr_low (addr_low),
        .rt_data  (rt_data),
        .st_data  (st_data),
        .mem_we   (mem_we)
    );

endmodule

//--- tb_ex_mem_unit.sv
`timescale 1ns/1ps

module tb_ex_mem_unit;
    import ex_pkg::*;

    logic       clk;
    logic       rst;
    word_t      src1;
    word_t      src2;
    logic       div_start;
    logic       div_signed;
    logic       div_ack;
    logic       div_busy;
    logic       div_done;
    logic       mul_en;
    logic       mul_signed;
    word_t      hi;
    word_t      lo;
    br_op_t     br_op;
    logic       br_taken;
    logic [1:0] addr_low;
    ld_op_t     ld_op;
    word_t      mem_rdata;
    logic       gr_we;
    word_t      ld_result;
    lane_mask_t reg_we_mask;
    st_op_t     st_op;
    word_t      rt_data;
    word_t      st_data;
    lane_mask_t mem_we;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    ex_mem_unit i_ex_mem_unit (
        .clk         (clk),
        .rst         (rst),
        .src1        (src1),
        .src2        (src2),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .div_ack     (div_ack),
        .div_busy    (div_busy),
        .div_done    (div_done),
        .mul_en      (mul_en),
        .mul_signed  (mul_signed),
        .hi          (hi),
        .lo          (lo),
        .br_op       (br_op),
        .br_taken    (br_taken),
        .addr_low    (addr_low),
        .ld_op       (ld_op),
        .mem_rdata   (mem_rdata),
        .gr_we       (gr_we),
        .ld_result   (ld_result),
        .reg_we_mask (reg_we_mask),
        .st_op       (st_op),
        .rt_data     (rt_data),
        .st_data     (st_data),
        .mem_we      (mem_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic test_reset();
        check("div_busy", div_busy, 1'b0);
        check("div_done", div_done, 1'b0);
        check("hi", hi, 32'h0);
        check("lo", lo, 32'h0);
    endtask

    // op index 6 drives an all-zero br_op
    task automatic apply_branch(input word_t a, input word_t b);
        logic taken_exp;
        for (int op = 0; op <= 6; op++) begin
            case (op)
                0: taken_exp = (a == b);
                1: taken_exp = (a != b);
                2: taken_exp = ($signed(a) >= 0);
                3: taken_exp = ($signed(a) > 0);
                4: taken_exp = ($signed(a) <= 0);
                5: taken_exp = ($signed(a) < 0);
                default: taken_exp = 1'b0;
            endcase
            @(negedge clk);
            src1  = a;
            src2  = b;
            br_op = (op < 6) ? br_op_t'(1 << op) : '0;
            @(posedge clk);
            check("br_taken", br_taken, taken_exp);
        end
    endtask

    task automatic test_branches();
        word_t r;
        apply_branch(32'h0, 32'h0);
        apply_branch(32'h0, 32'h1);
        apply_branch(32'h1, 32'h0);
        apply_branch(32'h8000_0000, 32'h8000_0000);
        apply_branch(32'h8000_0000, 32'h0);
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            apply_branch(r, next_rand());
            apply_branch(r, r);
            apply_branch(r & 32'h7fff_ffff, r);
            apply_branch(r | 32'h8000_0000, r);
        end
    endtask

    task automatic apply_multiply(input word_t a, input word_t b, input logic sgn);
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        ext_a = sgn ? {{32{a[31]}}, a} : {32'b0, a};
        ext_b = sgn ? {{32{b[31]}}, b} : {32'b0, b};
        prod  = ext_a * ext_b;
        @(negedge clk);
        src1       = a;
        src2       = b;
        mul_signed = sgn;
        mul_en     = 1'b1;
        @(negedge clk);
        mul_en = 1'b0;
        check("hi", hi, prod[63:32]);
        check("lo", lo, prod[31:0]);
    endtask

    task automatic test_multiply();
        word_t a;
        word_t b;
        apply_multiply(32'hffff_ffff, 32'hffff_ffff, 1'b0);
        apply_multiply(32'hffff_ffff, 32'hffff_ffff, 1'b1);
        apply_multiply(32'h8000_0000, 32'h8000_0000, 1'b1);
        for (int i = 0; i < 6; i++) begin
            a = next_rand();
            b = next_rand();
            apply_multiply(a, b, 1'b0);
            apply_multiply(a, b, 1'b1);
        end
    endtask

    task automatic wait_for_done(output int cycles, output logic ok);
        cycles = 1;
        while (!div_done && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        ok = div_done;
        if (!ok) begin
            errors++;
            $display("timeout: div_done did not rise within 100 cycles of div_start");
        end
    endtask

    task automatic apply_divide(input word_t a, input word_t b, input logic sgn);
        word_t a_mag;
        word_t b_mag;
        word_t q_exp;
        word_t r_exp;
        word_t hi_held;
        word_t lo_held;
        logic  a_neg;
        logic  b_neg;
        logic  ok;
        int    cycles;
        // truncating division where the remainder takes the dividend's sign
        a_neg = sgn && a[31];
        b_neg = sgn && b[31];
        a_mag = a_neg ? -a : a;
        b_mag = b_neg ? -b : b;
        q_exp = a_mag / b_mag;
        r_exp = a_mag % b_mag;
        if (a_neg != b_neg) begin
            q_exp = -q_exp;
        end
        if (a_neg) begin
            r_exp = -r_exp;
        end
        @(negedge clk);
        src1       = a;
        src2       = b;
        div_signed = sgn;
        div_start  = 1'b1;
        @(negedge clk);
        div_start = 1'b0;
        check("div_busy", div_busy, 1'b1);
        hi_held = hi;
        lo_held = lo;
        wait_for_done(cycles, ok);
        if (ok) begin
            check("div_latency", cycles, 35);
            repeat (4) begin
                @(negedge clk);
                check("div_done", div_done, 1'b1);
                check("hi", hi, hi_held);
                check("lo", lo, lo_held);
            end
            // a start while done must not reload the operands
            src1      = next_rand();
            src2      = next_rand();
            div_start = 1'b1;
            @(negedge clk);
            div_start = 1'b0;
            div_ack   = 1'b1;
            @(negedge clk);
            div_ack = 1'b0;
            check("div_done", div_done, 1'b0);
            check("div_busy", div_busy, 1'b0);
            check("hi", hi, r_exp);
            check("lo", lo, q_exp);
        end
    endtask

    task automatic test_divide();
        word_t n;
        word_t d;
        apply_divide(-32'sd100, 32'd7, 1'b1);
        apply_divide(32'd100, -32'sd7, 1'b1);
        apply_divide(-32'sd100, -32'sd7, 1'b1);
        apply_divide(32'h8000_0000, 32'd3, 1'b1);
        apply_divide(32'hffff_fff0, 32'd3, 1'b0);
        for (int i = 0; i < 4; i++) begin
            n = next_rand();
            d = next_rand() >> (8 * i);
            if (d == 0) begin
                d = 32'h1;
            end
            apply_divide(n, d, 1'b0);
            apply_divide(n, d, 1'b1);
        end
    endtask

    // op index 7 drives an all-zero ld_op
    task automatic apply_load(input int op, input int a, input word_t data, input logic we);
        word_t      exp_res;
        word_t      lane_bits;
        lane_mask_t exp_mask;
        logic       check_res;
        exp_res   = '0;
        exp_mask  = '1;
        check_res = 1'b1;
        case (op)
            0: begin
                // lwr fills register lanes 0 up from memory lane a
                for (int k = 0; k < 4; k++) begin
                    exp_mask[k] = (k + a <= 3);
                    if (k + a <= 3) begin
                        exp_res[8*k +: 8] = data[8*(k+a) +: 8];
                    end
                end
            end
            1: begin
                // lwl fills register lanes 3 down from memory lane a
                for (int k = 0; k < 4; k++) begin
                    exp_mask[k] = (k + a >= 3);
                    if (k + a >= 3) begin
                        exp_res[8*k +: 8] = data[8*(k+a-3) +: 8];
                    end
                end
            end
            2, 3: begin
                check_res = (a % 2 == 0);
                if (check_res) begin
                    exp_res[15:0] = data[8*a +: 16];
                    if (op == 3) begin
                        exp_res[31:16] = {16{exp_res[15]}};
                    end
                end
            end
            4, 5: begin
                exp_res[7:0] = data[8*a +: 8];
                if (op == 5) begin
                    exp_res[31:8] = {24{exp_res[7]}};
                end
            end
            6: exp_res = data;
            default: begin
                exp_mask  = {4{we}};
                check_res = 1'b0;
            end
        endcase
        for (int k = 0; k < 4; k++) begin
            lane_bits[8*k +: 8] = {8{exp_mask[k]}};
        end
        @(negedge clk);
        ld_op     = (op < 7) ? ld_op_t'(1 << op) : '0;
        addr_low  = 2'(a);
        mem_rdata = data;
        gr_we     = we;
        @(posedge clk);
        check("reg_we_mask", reg_we_mask, exp_mask);
        if (check_res) begin
            check("ld_result", ld_result & lane_bits, exp_res & lane_bits);
        end
    endtask

    task automatic test_loads();
        word_t data;
        for (int pass = 0; pass < 2; pass++) begin
            for (int op = 0; op < 8; op++) begin
                for (int a = 0; a < 4; a++) begin
                    data = next_rand();
                    if (pass == 1) begin
                        data = data | 32'h8080_8080;
                    end
                    apply_load(op, a, data, data[0]);
                end
            end
        end
        apply_load(7, 0, next_rand(), 1'b1);
        apply_load(7, 0, next_rand(), 1'b0);
    endtask

    // op index 5 drives an all-zero st_op
    task automatic apply_store(input int op, input int a, input word_t rt);
        word_t      exp_data;
        word_t      lane_bits;
        lane_mask_t exp_we;
        int         src;
        exp_data = '0;
        exp_we   = '0;
        for (int j = 0; j < 4; j++) begin
            src = -1;
            case (op)
                0: src = j - a;
                1: src = j + 3 - a;
                2: begin
                    // misaligned halfword writes no lane
                    if (a % 2 == 0 && j - a <= 1) begin
                        src = j - a;
                    end
                end
                3: begin
                    if (j == a) begin
                        src = 0;
                    end
                end
                4: src = j;
                default: src = -1;
            endcase
            if (src >= 0 && src <= 3) begin
                exp_we[j]           = 1'b1;
                exp_data[8*j +: 8] = rt[8*src +: 8];
            end
            lane_bits[8*j +: 8] = {8{exp_we[j]}};
        end
        @(negedge clk);
        st_op    = (op < 5) ? st_op_t'(1 << op) : '0;
        addr_low = 2'(a);
        rt_data  = rt;
        @(posedge clk);
        check("mem_we", mem_we, exp_we);
        if (exp_we != '0) begin
            check("st_data", st_data & lane_bits, exp_data & lane_bits);
        end
    endtask

    task automatic test_stores();
        for (int op = 0; op < 6; op++) begin
            for (int a = 0; a < 4; a++) begin
                apply_store(op, a, next_rand());
            end
        end
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        lcg_state  = 32'hea23_89c2;
        rst        = 1'b1;
        src1       = '0;
        src2       = '0;
        div_start  = 1'b0;
        div_signed = 1'b0;
        div_ack    = 1'b0;
        mul_en     = 1'b0;
        mul_signed = 1'b0;
        br_op      = '0;
        addr_low   = 2'b00;
        ld_op      = '0;
        mem_rdata  = '0;
        gr_we      = 1'b0;
        st_op      = '0;
        rt_data    = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_branches();
        test_multiply();
        test_divide();
        test_loads();
        test_stores();
        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- ex_mem_unit.f
+incdir+.
ex_pkg.sv
ex_ctrl.sv
div_iter.sv
hilo_unit.sv
br_comp.sv
ld_align.sv
st_align.sv
ex_mem_unit.sv
tb_ex_mem_unit.sv
